/* all.f */
logic/unwrap_pkg.sv
logic/lane_if.sv
logic/axil_regs.sv
logic/seed_dispatch.sv
logic/unwrap_lane.sv
logic/result_collect.sv
logic/obf_unwrap_top.sv
tb/unwrap_sva.sv
tb/unwrap_checker.sv
tb/obf_unwrap_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -j 0 -f all.f --top-module obf_unwrap_tb -o obf_unwrap_sim \
    && ./obj_dir/obf_unwrap_sim | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null \
    && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* tb/obf_unwrap_tb.sv */
// Testbench for the key unwrap block, driving AXI4-Lite traffic from an LFSR
`timescale 1ns/1ps

module obf_unwrap_tb import unwrap_pkg::*; ();

    localparam int NUM_RUNS   = 8;
    // Seed phase, error phase and each run take well under this with stalls
    localparam int RUN_CYCLES = 200;
    localparam int MAX_CYCLES = (NUM_RUNS + 4) * RUN_CYCLES;

    logic                             core_clk = 1'b0;
    logic                             rst_n;
    logic [NUM_LANES-1:0][DATA_W-1:0] obf_key;
    logic [ADDR_W-1:0]                awaddr;
    logic                             awvalid;
    logic                             awready;
    logic [DATA_W-1:0]                wdata;
    logic [DATA_W/8-1:0]              wstrb;
    logic                             wvalid;
    logic                             wready;
    logic [1:0]                       bresp;
    logic                             bvalid;
    logic                             bready;
    logic [ADDR_W-1:0]                araddr;
    logic                             arvalid;
    logic                             arready;
    logic [DATA_W-1:0]                rdata;
    logic [1:0]                       rresp;
    logic                             rvalid;
    logic                             rready;

    logic [31:0] lfsr_state = 32'd15;
    logic        stall_en   = 1'b1;
    int          cycles     = 0;
    int          chk_errors;
    int          chk_outstanding;

    always #4 core_clk = ~core_clk;

    obf_unwrap_top i_obf_unwrap_top (.*);

    unwrap_checker i_unwrap_checker (.*, .errors(chk_errors), .outstanding(chk_outstanding));

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Ready is dropped about one cycle in four
    function automatic logic ready_draw();
        return !stall_en || (take_bits(2) != 0);
    endfunction

    function automatic logic [ADDR_W-1:0] slot_addr(input logic [1:0] region, input int lane);
        return {region, 2'(lane), 4'b0000};
    endfunction

    function automatic logic [ADDR_W-1:0] ctrl_addr(input logic [3:0] sel);
        return {REGION_CTRL, sel, 2'b00};
    endfunction

    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [DATA_W/8-1:0] strb);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        @(posedge core_clk);
        while (!awready) @(posedge core_clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do begin
            bready <= ready_draw();
            @(posedge core_clk);
        end while (!(bvalid && bready));
        bready <= 1'b0;
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(posedge core_clk);
        while (!arready) @(posedge core_clk);
        arvalid <= 1'b0;
        do begin
            rready <= ready_draw();
            @(posedge core_clk);
        end while (!(rvalid && rready));
        data = rdata;
        rready <= 1'b0;
    endtask

    // Poll status until busy is gone and done is set
    task automatic wait_done();
        logic [DATA_W-1:0] status;
        status = '0;
        while (status[1:0] != 2'b01) begin
            read_reg(ctrl_addr(CTRL_SEL_STATUS), status);
        end
    endtask

    initial begin
        logic [DATA_W-1:0] rd;
        logic [ADDR_W-1:0] addr;
        rst_n   = 1'b0;
        obf_key = '0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (16) @(posedge core_clk);
        rst_n <= 1'b1;
        @(posedge core_clk);

        // Seed readback, second write with random byte enables
        for (int i = 0; i < NUM_LANES; i++) begin
            write_reg(slot_addr(REGION_SEED, i), take_bits(32), 4'hf);
            write_reg(slot_addr(REGION_SEED, i), take_bits(32), 4'(take_bits(4)));
            read_reg(slot_addr(REGION_SEED, i), rd);
        end

        for (int r = 0; r < NUM_RUNS; r++) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                obf_key[i] <= take_bits(32);
            end
            for (int i = 0; i < NUM_LANES; i++) begin
                write_reg(slot_addr(REGION_SEED, i), take_bits(32), 4'hf);
            end
            // Some runs get a seed write and a second start while busy
            stall_en = (r % 3 != 2);
            write_reg(ctrl_addr(CTRL_SEL_CONTROL), 32'd1, 4'h1);
            if (r % 3 == 2) begin
                write_reg(slot_addr(REGION_SEED, 0), take_bits(32), 4'hf);
                write_reg(ctrl_addr(CTRL_SEL_CONTROL), 32'd1, 4'h1);
            end
            stall_en = 1'b1;
            wait_done();
            for (int i = 0; i < NUM_LANES; i++) begin
                read_reg(slot_addr(REGION_RESULT, i), rd);
                read_reg(slot_addr(REGION_SEED, i), rd);
            end
        end

        // Random addresses, start bit kept clear
        for (int i = 0; i < 12; i++) begin
            addr = 8'(take_bits(8));
            read_reg(addr, rd);
            write_reg(addr, take_bits(32) & ~32'd1, 4'hf);
        end
        write_reg(ctrl_addr(CTRL_SEL_STATUS), take_bits(32), 4'hf);
        write_reg(slot_addr(REGION_RESULT, 1), take_bits(32), 4'hf);
        addr = {2'b11, 6'(take_bits(6))};
        write_reg(addr, take_bits(32), 4'hf);
        read_reg(addr, rd);

        repeat (4) @(posedge core_clk);
        $display("Closing counts: %0d check errors, %0d responses outstanding",
                 chk_errors, chk_outstanding);
        if (chk_errors == 0 && chk_outstanding == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    always @(posedge core_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

endmodule

/* tb/unwrap_checker.sv */
// Checker mirroring seeds, key and run state and comparing AXI4-Lite responses
`timescale 1ns/1ps

module unwrap_checker import unwrap_pkg::*; (
    input  logic                             core_clk,
    input  logic                             rst_n,
    input  logic [NUM_LANES-1:0][DATA_W-1:0] obf_key,
    input  logic [ADDR_W-1:0]                awaddr,
    input  logic                             awvalid,
    input  logic                             awready,
    input  logic [DATA_W-1:0]                wdata,
    input  logic [DATA_W/8-1:0]              wstrb,
    input  logic                             wready,
    input  logic [1:0]                       bresp,
    input  logic                             bvalid,
    input  logic                             bready,
    input  logic [ADDR_W-1:0]                araddr,
    input  logic                             arvalid,
    input  logic                             arready,
    input  logic [DATA_W-1:0]                rdata,
    input  logic [1:0]                       rresp,
    input  logic                             rvalid,
    input  logic                             rready,
    output int                               errors,
    output int                               outstanding
);

    logic [NUM_LANES-1:0][DATA_W-1:0] seed_m;
    logic [NUM_LANES-1:0][DATA_W-1:0] result_m;
    logic [NUM_LANES-1:0][DATA_W-1:0] pending_m;
    logic                             running;
    logic                             done_m;
    logic [1:0]                       bresp_q [$];
    logic [1:0]                       rresp_q [$];
    logic [DATA_W-1:0]                rdata_q [$];
    logic                             status_q [$];

    function automatic logic [DATA_W-1:0] rotl(input logic [DATA_W-1:0] v, input int n);
        return (v << n) | (v >> (DATA_W - n));
    endfunction

    // Reference unwrap of one seed word
    function automatic logic [DATA_W-1:0] unwrap_ref(input logic [DATA_W-1:0] seed,
                                                     input logic [DATA_W-1:0] key);
        logic [DATA_W-1:0] w;
        logic [DATA_W-1:0] k;
        w = seed;
        k = key;
        for (int r = 0; r < ROUNDS; r++) begin
            w = rotl(w ^ k, 7) + MIX_CONST;
            k = rotl(k, 3);
        end
        return w;
    endfunction

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    always @(posedge core_clk) begin
        reg_addr_u         a;
        logic [1:0]        exp_resp;
        logic [DATA_W-1:0] exp_data;
        logic              is_status;
        if (!rst_n) begin
            seed_m   = '0;
            result_m = '0;
            running  = 1'b0;
            done_m   = 1'b0;
            errors   = 0;
            bresp_q.delete();
            rresp_q.delete();
            rdata_q.delete();
            status_q.delete();
        end else begin
            // Address and data of a write are taken in the same cycle
            check_value("wready", DATA_W'(awready), DATA_W'(wready));

            if (arvalid && arready) begin
                a         = araddr;
                exp_resp  = RESP_DECERR;
                exp_data  = '0;
                is_status = 1'b0;
                if ((a.slot.region == REGION_SEED || a.slot.region == REGION_RESULT) &&
                    a.slot.unused == 2'b00 && a.slot.byte_off == 2'b00) begin
                    exp_resp = RESP_OKAY;
                    exp_data = (a.slot.region == REGION_SEED) ? seed_m[a.slot.lane]
                                                              : result_m[a.slot.lane];
                end else if (a.ctrl.region == REGION_CTRL && a.ctrl.byte_off == 2'b00 &&
                             (a.ctrl.sel == CTRL_SEL_CONTROL ||
                              a.ctrl.sel == CTRL_SEL_STATUS)) begin
                    exp_resp  = RESP_OKAY;
                    is_status = (a.ctrl.sel == CTRL_SEL_STATUS);
                end
                rresp_q.push_back(exp_resp);
                rdata_q.push_back(exp_data);
                status_q.push_back(is_status);
            end

            if (awvalid && awready) begin
                a        = awaddr;
                exp_resp = RESP_DECERR;
                if (a.slot.region == REGION_SEED && a.slot.unused == 2'b00 &&
                    a.slot.byte_off == 2'b00) begin
                    exp_resp = running ? RESP_SLVERR : RESP_OKAY;
                    for (int b = 0; b < DATA_W/8; b++) begin
                        if (!running && wstrb[b]) begin
                            seed_m[a.slot.lane][8*b +: 8] = wdata[8*b +: 8];
                        end
                    end
                end else if (a.slot.region == REGION_RESULT && a.slot.unused == 2'b00 &&
                             a.slot.byte_off == 2'b00) begin
                    exp_resp = RESP_SLVERR;
                end else if (a.ctrl.region == REGION_CTRL && a.ctrl.byte_off == 2'b00) begin
                    if (a.ctrl.sel == CTRL_SEL_CONTROL) begin
                        exp_resp = running ? RESP_SLVERR : RESP_OKAY;
                        if (!running && wstrb[0] && wdata[0]) begin
                            // Key is the one on the port when the run starts
                            for (int i = 0; i < NUM_LANES; i++) begin
                                pending_m[i] = unwrap_ref(seed_m[i], obf_key[i]);
                            end
                            running = 1'b1;
                            done_m  = 1'b0;
                        end
                    end else if (a.ctrl.sel == CTRL_SEL_STATUS) begin
                        exp_resp = RESP_SLVERR;
                    end
                end
                bresp_q.push_back(exp_resp);
            end

            if (bvalid && bready) begin
                if (bresp_q.size() == 0) begin
                    $display("%0t: write response with no write outstanding", $time);
                    errors++;
                end else begin
                    exp_resp = bresp_q.pop_front();
                    check_value("bresp", DATA_W'(exp_resp), DATA_W'(bresp));
                end
            end

            if (rvalid && rready) begin
                if (rresp_q.size() == 0) begin
                    $display("%0t: read response with no read outstanding", $time);
                    errors++;
                end else begin
                    exp_resp  = rresp_q.pop_front();
                    exp_data  = rdata_q.pop_front();
                    is_status = status_q.pop_front();
                    check_value("rresp", DATA_W'(exp_resp), DATA_W'(rresp));
                    if (!is_status) begin
                        check_value("rdata", exp_data, rdata);
                    end else if (!running) begin
                        check_value("rdata", DATA_W'({1'b0, done_m}), rdata);
                    end else if (rdata[DATA_W-1:2] != '0 || rdata[1:0] == 2'b00) begin
                        $display("%0t: status during a run shows neither busy nor done", $time);
                        errors++;
                    end else if (!rdata[1]) begin
                        // Busy gone, the run's results are in place
                        running  = 1'b0;
                        done_m   = 1'b1;
                        result_m = pending_m;
                    end
                end
            end
        end
        outstanding = bresp_q.size() + rresp_q.size();
    end

endmodule

/* tb/unwrap_sva.sv */
// Assertions on the AXI4-Lite response channels and the run start pulse
`timescale 1ns/1ps

module unwrap_sva import unwrap_pkg::*; (
    input logic              core_clk,
    input logic              rst_n,
    input logic [1:0]        bresp,
    input logic              bvalid,
    input logic              bready,
    input logic [DATA_W-1:0] rdata,
    input logic [1:0]        rresp,
    input logic              rvalid,
    input logic              rready,
    input logic              start,
    input logic              busy
);

    // A response holds with its payload until taken
    b_hold: assert property (@(posedge core_clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("bvalid dropped or bresp changed before bready");

    r_hold: assert property (@(posedge core_clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("rvalid dropped or read payload changed before rready");

    rst_idle: assert property (@(posedge core_clk) !rst_n |=> !bvalid && !rvalid)
        else $error("response valid high right after reset");

    start_idle: assert property (@(posedge core_clk) disable iff (!rst_n) start |-> !busy)
        else $error("start pulse while a run is busy");

endmodule

bind axil_regs unwrap_sva i_unwrap_sva (.*);

/* logic/obf_unwrap_top.sv */
// Key unwrap top level joining the AXI4-Lite registers, dispatcher, lanes and collector
`timescale 1ns/1ps

module obf_unwrap_top import unwrap_pkg::*; (
    input  logic                             core_clk,
    input  logic                             rst_n,
    input  logic [NUM_LANES-1:0][DATA_W-1:0] obf_key,

    // AXI4-Lite subordinate
    input  logic [ADDR_W-1:0]                awaddr,
    input  logic                             awvalid,
    output logic                             awready,
    input  logic [DATA_W-1:0]                wdata,
    input  logic [DATA_W/8-1:0]              wstrb,
    input  logic                             wvalid,
    output logic                             wready,
    output logic [1:0]                       bresp,
    output logic                             bvalid,
    input  logic                             bready,
    input  logic [ADDR_W-1:0]                araddr,
    input  logic                             arvalid,
    output logic                             arready,
    output logic [DATA_W-1:0]                rdata,
    output logic [1:0]                       rresp,
    output logic                             rvalid,
    input  logic                             rready
);

    logic                             start;
    logic                             busy;
    logic                             done;
    logic                             finish;
    logic [NUM_LANES-1:0][DATA_W-1:0] seeds;
    logic [NUM_LANES-1:0][DATA_W-1:0] results;

    lane_if lane_bus [NUM_LANES] ();

    axil_regs i_axil_regs (
        .core_clk (core_clk),
        .rst_n    (rst_n),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .busy     (busy),
        .done     (done),
        .results  (results),
        .start    (start),
        .seeds    (seeds)
    );

    seed_dispatch i_seed_dispatch (
        .core_clk (core_clk),
        .rst_n    (rst_n),
        .start    (start),
        .seeds    (seeds),
        .obf_key  (obf_key),
        .finish   (finish),
        .busy     (busy),
        .lanes    (lane_bus)
    );

    // One lane per key word
    for (genvar gi = 0; gi < NUM_LANES; gi++) begin : g_lane
        unwrap_lane i_unwrap_lane (
            .core_clk (core_clk),
            .rst_n    (rst_n),
            .lane     (lane_bus[gi])
        );
    end

    result_collect i_result_collect (
        .core_clk (core_clk),
        .rst_n    (rst_n),
        .lanes    (lane_bus),
        .start    (start),
        .results  (results),
        .done     (done),
        .finish   (finish)
    );

endmodule

/* logic/result_collect.sv */
// Result collector latching lane outputs, keeping sticky done and ending the run
`timescale 1ns/1ps

module result_collect import unwrap_pkg::*; (
    input  logic                             core_clk,
    input  logic                             rst_n,
    lane_if.drain                            lanes [NUM_LANES],
    input  logic                             start,
    output logic [NUM_LANES-1:0][DATA_W-1:0] results,
    output logic                             done,
    output logic                             finish
);

    logic [NUM_LANES-1:0] lane_done;
    logic [NUM_LANES-1:0] reported;
    logic [NUM_LANES-1:0] reported_next;

    for (genvar gi = 0; gi < NUM_LANES; gi++) begin : g_drain
        assign lane_done[gi] = lanes[gi].done;

        // Result words stay readable between runs
        always_ff @(posedge core_clk) begin
            if (!rst_n) begin
                results[gi] <= '0;
            end else if (lanes[gi].done) begin
                results[gi] <= lanes[gi].result;
            end
        end
    end

    assign reported_next = reported | lane_done;

    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            reported <= '0;
            done     <= 1'b0;
            finish   <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                reported <= '0;
                done     <= 1'b0;
            end else if (&reported_next) begin
                // Last lane in, run complete
                reported <= '0;
                done     <= 1'b1;
                finish   <= 1'b1;
            end else begin
                reported <= reported_next;
            end
        end
    end

endmodule

/* logic/unwrap_lane.sv */
// Unwrap lane applying the mixing round once per cycle over ROUNDS cycles
`timescale 1ns/1ps

module unwrap_lane import unwrap_pkg::*; (
    input  logic core_clk,
    input  logic rst_n,
    lane_if.lane lane
);

    logic               run;
    logic               done_q;
    logic [ROUND_W-1:0] round_cnt;
    logic [DATA_W-1:0]  word;
    logic [DATA_W-1:0]  key_q;

    // XOR with key, rotate left by 7, add constant
    function automatic logic [DATA_W-1:0] mix_round(input logic [DATA_W-1:0] w,
                                                    input logic [DATA_W-1:0] k);
        logic [DATA_W-1:0] x;
        x = w ^ k;
        return {x[DATA_W-8:0], x[DATA_W-1:DATA_W-7]} + MIX_CONST;
    endfunction

    function automatic logic [DATA_W-1:0] rotl3(input logic [DATA_W-1:0] k);
        return {k[DATA_W-4:0], k[DATA_W-1:DATA_W-3]};
    endfunction

    // Round control, first round happens on the start edge
    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            run       <= 1'b0;
            done_q    <= 1'b0;
            round_cnt <= '0;
        end else begin
            done_q <= 1'b0;
            if (lane.start) begin
                run       <= 1'b1;
                round_cnt <= ROUND_W'(1);
            end else if (run) begin
                round_cnt <= round_cnt + 1'b1;
                if (round_cnt == ROUND_W'(ROUNDS - 1)) begin
                    run    <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (lane.start) begin
            word  <= mix_round(lane.seed, lane.key);
            key_q <= rotl3(lane.key);
        end else if (run) begin
            word  <= mix_round(word, key_q);
            key_q <= rotl3(key_q);
        end
    end

    // Word holds after the last round
    assign lane.done   = done_q;
    assign lane.result = word;

endmodule

/* logic/seed_dispatch.sv */
// Run dispatcher holding busy, latching key and seeds and launching every lane
`timescale 1ns/1ps

module seed_dispatch import unwrap_pkg::*; (
    input  logic                             core_clk,
    input  logic                             rst_n,
    input  logic                             start,
    input  logic [NUM_LANES-1:0][DATA_W-1:0] seeds,
    input  logic [NUM_LANES-1:0][DATA_W-1:0] obf_key,
    input  logic                             finish,
    output logic                             busy,
    lane_if.feed                             lanes [NUM_LANES]
);

    logic                             launch;
    logic [NUM_LANES-1:0][DATA_W-1:0] seed_q;
    logic [NUM_LANES-1:0][DATA_W-1:0] key_q;

    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            launch <= 1'b0;
        end else begin
            // Lanes see start one cycle after the pulse
            launch <= start && !busy;
            if (start && !busy) begin
                busy <= 1'b1;
            end else if (finish) begin
                busy <= 1'b0;
            end
        end
    end

    // Key is sampled at start so the lanes see a stable word all run long
    always_ff @(posedge core_clk) begin
        if (start && !busy) begin
            seed_q <= seeds;
            key_q  <= obf_key;
        end
    end

    for (genvar gi = 0; gi < NUM_LANES; gi++) begin : g_feed
        assign lanes[gi].start = launch;
        assign lanes[gi].seed  = seed_q[gi];
        assign lanes[gi].key   = key_q[gi];
    end

endmodule

/* logic/axil_regs.sv */
// AXI4-Lite register block with seed storage, result and status reads, error responses
`timescale 1ns/1ps

module axil_regs import unwrap_pkg::*; (
    input  logic                             core_clk,
    input  logic                             rst_n,

    input  logic [ADDR_W-1:0]                awaddr,
    input  logic                             awvalid,
    output logic                             awready,
    input  logic [DATA_W-1:0]                wdata,
    input  logic [DATA_W/8-1:0]              wstrb,
    input  logic                             wvalid,
    output logic                             wready,
    output logic [1:0]                       bresp,
    output logic                             bvalid,
    input  logic                             bready,
    input  logic [ADDR_W-1:0]                araddr,
    input  logic                             arvalid,
    output logic                             arready,
    output logic [DATA_W-1:0]                rdata,
    output logic [1:0]                       rresp,
    output logic                             rvalid,
    input  logic                             rready,

    input  logic                             busy,
    input  logic                             done,
    input  logic [NUM_LANES-1:0][DATA_W-1:0] results,
    output logic                             start,
    output logic [NUM_LANES-1:0][DATA_W-1:0] seeds
);

    reg_addr_u         waddr_u;
    reg_addr_u         raddr_u;
    logic              wr_accept;
    logic              rd_accept;
    logic              w_slot_ok;
    logic              r_slot_ok;
    logic              seed_we;
    logic              start_req;
    logic [1:0]        wr_resp;
    logic [1:0]        rd_resp;
    logic [DATA_W-1:0] rd_data;

    assign waddr_u = awaddr;
    assign raddr_u = araddr;

    // Address and data are taken together, and only once the last B is gone
    assign awready   = awvalid && wvalid && !bvalid;
    assign wready    = awready;
    assign wr_accept = awready;

    assign arready   = !rvalid;
    assign rd_accept = arvalid && arready;

    // Slots are word aligned with the spare bits clear
    assign w_slot_ok = (waddr_u.slot.unused == 2'b00) && (waddr_u.slot.byte_off == 2'b00);
    assign r_slot_ok = (raddr_u.slot.unused == 2'b00) && (raddr_u.slot.byte_off == 2'b00);

    // Write decode
    always_comb begin
        wr_resp   = RESP_DECERR;
        seed_we   = 1'b0;
        start_req = 1'b0;
        case (waddr_u.slot.region)
            REGION_SEED: begin
                if (w_slot_ok) begin
                    // Seeds are frozen while a run is in flight
                    wr_resp = busy ? RESP_SLVERR : RESP_OKAY;
                    seed_we = !busy;
                end
            end
            REGION_RESULT: begin
                if (w_slot_ok) begin
                    wr_resp = RESP_SLVERR;
                end
            end
            REGION_CTRL: begin
                if (waddr_u.ctrl.byte_off == 2'b00) begin
                    if (waddr_u.ctrl.sel == CTRL_SEL_CONTROL) begin
                        wr_resp   = busy ? RESP_SLVERR : RESP_OKAY;
                        start_req = !busy && wstrb[0] && wdata[0];
                    end else if (waddr_u.ctrl.sel == CTRL_SEL_STATUS) begin
                        wr_resp = RESP_SLVERR;
                    end
                end
            end
            default: begin
                wr_resp = RESP_DECERR;
            end
        endcase
    end

    // Read decode
    always_comb begin
        rd_resp = RESP_DECERR;
        rd_data = '0;
        case (raddr_u.slot.region)
            REGION_SEED: begin
                if (r_slot_ok) begin
                    rd_resp = RESP_OKAY;
                    rd_data = seeds[raddr_u.slot.lane];
                end
            end
            REGION_RESULT: begin
                if (r_slot_ok) begin
                    rd_resp = RESP_OKAY;
                    rd_data = results[raddr_u.slot.lane];
                end
            end
            REGION_CTRL: begin
                if (raddr_u.ctrl.byte_off == 2'b00) begin
                    if (raddr_u.ctrl.sel == CTRL_SEL_CONTROL) begin
                        // Start bit is self clearing
                        rd_resp = RESP_OKAY;
                    end else if (raddr_u.ctrl.sel == CTRL_SEL_STATUS) begin
                        rd_resp      = RESP_OKAY;
                        rd_data[1:0] = {busy, done};
                    end
                end
            end
            default: begin
                rd_resp = RESP_DECERR;
            end
        endcase
    end

    // Handshake state and start pulse
    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            start  <= 1'b0;
        end else begin
            start <= wr_accept && start_req;
            if (wr_accept) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_accept) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Response payloads
    always_ff @(posedge core_clk) begin
        if (wr_accept) begin
            bresp <= wr_resp;
        end
        if (rd_accept) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

    // Seed words with byte enables
    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            seeds <= '0;
        end else if (wr_accept && seed_we) begin
            for (int b = 0; b < DATA_W/8; b++) begin
                if (wstrb[b]) begin
                    seeds[waddr_u.slot.lane][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

/* logic/lane_if.sv */
// Lane interface carrying launch, seed and key out and done with result back
`timescale 1ns/1ps

interface lane_if import unwrap_pkg::*; ();

    logic              start;
    logic [DATA_W-1:0] seed;
    logic [DATA_W-1:0] key;
    logic              done;
    logic [DATA_W-1:0] result;

    // Dispatcher side
    modport feed (
        output start, seed, key
    );

    modport lane (
        input  start, seed, key,
        output done, result
    );

    // Collector only watches the return path
    modport drain (
        input done, result
    );

endinterface

/* logic/unwrap_pkg.sv */
// Key unwrap package with sizes, mixing constants, address map and AXI response codes
package unwrap_pkg;

    // Lane count is fixed by the four seed and result slots of the map
    localparam int NUM_LANES = 4;
    localparam int ROUNDS    = 4;
    localparam int ROUND_W   = $clog2(ROUNDS);
    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 8;

    localparam logic [DATA_W-1:0] MIX_CONST = 32'h9e37_79b9;

    // Region codes in address bits 7:6
    localparam logic [1:0] REGION_SEED   = 2'd0;
    localparam logic [1:0] REGION_RESULT = 2'd1;
    localparam logic [1:0] REGION_CTRL   = 2'd2;

    // Register selects inside the control region
    localparam logic [3:0] CTRL_SEL_CONTROL = 4'd0;
    localparam logic [3:0] CTRL_SEL_STATUS  = 4'd1;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    // One register address, seen either as a slot or as a control register
    typedef union packed {
        struct packed {
            logic [1:0] region;
            logic [1:0] lane;
            logic [1:0] unused;
            logic [1:0] byte_off;
        } slot;
        struct packed {
            logic [1:0] region;
            logic [3:0] sel;
            logic [1:0] byte_off;
        } ctrl;
    } reg_addr_u;

endpackage
